/* vlog.f */
+incdir+rtl
rtl/harness_pkg.sv
rtl/axil_req_stage.sv
rtl/region_decode_stage.sv
rtl/mem_access_stage.sv
rtl/axil_resp_stage.sv
rtl/mem_harness_top.sv
tests/tb_mem_harness.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_mem_harness
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := TEST RESULT: PASS
LINT_FLAGS := --lint-only --timing -Wno-fatal
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) rtl/harness_config.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/tb_mem_harness.sv */
// Testbench for the AXI4-Lite memory harness
// The shadow DRAM only knows what was written, so DRAM reads follow a full write
// One request is offered at a time; responses are checked in issue order
`timescale 1ns/1ps
`include "harness_config.svh"

module tb_mem_harness;

  localparam int          timeout_cycles = 50;
  localparam logic [1:0]  resp_okay      = 2'd0;
  localparam logic [1:0]  resp_slverr    = 2'd2;
  localparam logic [1:0]  resp_decerr    = 2'd3;
  localparam logic [31:0] rom_base       = `HARNESS_ROM_BASE;
  localparam logic [31:0] rom_end        = rom_base + `HARNESS_ROM_WORDS * 4;
  localparam logic [31:0] dram_base      = `HARNESS_DRAM_BASE;
  localparam logic [31:0] dram_end       = dram_base + `HARNESS_DRAM_WORDS * 4;

  typedef struct packed {
    logic        write;
    logic [1:0]  resp;
    logic [31:0] data;
  } expect_t;

  logic        clk;
  logic        ndmreset_n;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [31:0] awaddr, wdata, araddr, rdata;
  logic [3:0]  wstrb;
  logic [1:0]  bresp, rresp;

  logic [31:0] shadow_dram [`HARNESS_DRAM_WORDS];
  expect_t     expect_q [$];
  string       name_q [$];
  string       test_name = "reset";
  int          error_count = 0;
  int          checked_count = 0;

  mem_harness_top mem_harness_top_i (
    .clk_i      (clk),
    .ndmreset_n (ndmreset_n),
    .awvalid_i  (awvalid),
    .awaddr_i   (awaddr),
    .awready_o  (awready),
    .wvalid_i   (wvalid),
    .wdata_i    (wdata),
    .wstrb_i    (wstrb),
    .wready_o   (wready),
    .bvalid_o   (bvalid),
    .bresp_o    (bresp),
    .bready_i   (bready),
    .arvalid_i  (arvalid),
    .araddr_i   (araddr),
    .arready_o  (arready),
    .rvalid_o   (rvalid),
    .rdata_o    (rdata),
    .rresp_o    (rresp),
    .rready_i   (rready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic expect_t model_access(input logic is_write, input logic [31:0] addr,
                                           input logic [31:0] data, input logic [3:0] strb);
    expect_t     e;
    int unsigned idx;
    e.write = is_write;
    e.resp  = resp_okay;
    e.data  = '0;
    if (addr >= rom_base && addr < rom_end) begin
      idx = (addr - rom_base) / 4;
      if (is_write) begin
        e.resp = resp_slverr;
      end else begin
        e.data = {`HARNESS_ROM_TAG, idx[15:0]};
      end
    end else if (addr >= dram_base && addr < dram_end) begin
      idx = (addr - dram_base) / 4;
      if (is_write) begin
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) begin
            shadow_dram[idx][b*8 +: 8] = data[b*8 +: 8];
          end
        end
      end else begin
        e.data = shadow_dram[idx];
      end
    end else begin
      e.resp = resp_decerr;
    end
    return e;
  endfunction

  // ----------------------------------------------------------------------
  // Request drivers, entered 1 ns after a rising edge
  // ----------------------------------------------------------------------
  task automatic issue_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    int waited;
    waited  = 0;
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    @(negedge clk);
    while (!(awready && wready) && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (awready && wready) begin
      expect_q.push_back(model_access(1'b1, addr, data, strb));
      name_q.push_back(test_name);
    end else begin
      $display("Timeout in %s: write to %h was never accepted", test_name, addr);
      error_count++;
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic issue_read(input logic [31:0] addr);
    int waited;
    waited  = 0;
    arvalid = 1'b1;
    araddr  = addr;
    @(negedge clk);
    while (!arready && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (arready) begin
      expect_q.push_back(model_access(1'b0, addr, '0, '0));
      name_q.push_back(test_name);
    end else begin
      $display("Timeout in %s: read of %h was never accepted", test_name, addr);
      error_count++;
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (expect_q.size() != 0 && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (expect_q.size() != 0) begin
      $display("Timeout in %s: %0d responses never arrived", test_name, expect_q.size());
      error_count++;
      expect_q.delete();
      name_q.delete();
    end
    @(posedge clk);
    #1;
  endtask

  task automatic check_dram_random(input int rounds);
    logic [31:0] addr;
    for (int i = 0; i < rounds; i++) begin
      // Byte offset bits are ignored by the DUT
      addr = dram_base + ($urandom % `HARNESS_DRAM_WORDS) * 4 + ($urandom % 4);
      issue_write(addr, $urandom, 4'hF);
      issue_write(addr, $urandom, 4'($urandom));
      issue_read(addr);
    end
  endtask

  task automatic check_read_latency(input logic [31:0] addr);
    int cycles;
    cycles = 0;
    issue_read(addr);
    do begin
      @(negedge clk);
      cycles++;
    end while (!rvalid && cycles < timeout_cycles);
    if (!rvalid) begin
      $display("Timeout in %s: rvalid never rose", test_name);
      error_count++;
    end else if (cycles != 3) begin
      $display("ERROR %s: latency expected 3 actual %0d", test_name, cycles);
      error_count++;
    end
  endtask

  task automatic check_backpressure();
    bready = 1'b0;
    rready = 1'b0;
    issue_write(dram_base + 200 * 4, 32'hA5A5_0001, 4'hF);
    issue_write(dram_base + 201 * 4, 32'h5A5A_0002, 4'hF);
    issue_read(dram_base + 201 * 4);
    issue_read(dram_base + 200 * 4);
    fork
      issue_read(rom_base + 9 * 4);
      begin
        // Queue is full, so no credit for the fifth request
        repeat (6) begin
          @(negedge clk);
          if (arready !== 1'b0) begin
            $display("ERROR %s: arready expected 0 actual %b", test_name, arready);
            error_count++;
          end
        end
        @(posedge clk);
        #1;
        bready = 1'b1;
        rready = 1'b1;
      end
    join
  endtask

  // ----------------------------------------------------------------------
  // Response checker
  // ----------------------------------------------------------------------
  initial begin : compare_responses
    expect_t e;
    string   name;
    forever begin
      @(negedge clk);
      if (ndmreset_n && ((bvalid && bready) || (rvalid && rready))) begin
        if (expect_q.size() == 0) begin
          $display("Response arrived with no request outstanding");
          error_count++;
        end else begin
          e    = expect_q.pop_front();
          name = name_q.pop_front();
          checked_count++;
          if (bvalid != e.write) begin
            $display("%s: response came on the wrong channel", name);
            error_count++;
          end else if (bvalid) begin
            if (bresp !== e.resp) begin
              $display("ERROR %s: bresp expected %0d actual %0d", name, e.resp, bresp);
              error_count++;
            end
          end else begin
            if (rresp !== e.resp) begin
              $display("ERROR %s: rresp expected %0d actual %0d", name, e.resp, rresp);
              error_count++;
            end
            if (rdata !== e.data) begin
              $display("ERROR %s: rdata expected %h actual %h", name, e.data, rdata);
              error_count++;
            end
          end
        end
      end
    end
  end

  initial begin : main
    int rom_idx [5] = '{0, 1, 17, 42, 63};
    void'($urandom(5823));
    ndmreset_n = 1'b0;
    awvalid    = 1'b0;
    awaddr     = '0;
    wvalid     = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    bready     = 1'b0;
    arvalid    = 1'b0;
    araddr     = '0;
    rready     = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    ndmreset_n = 1'b1;
    bready     = 1'b1;
    rready     = 1'b1;
    @(negedge clk);
    if (bvalid || rvalid) begin
      $display("A response channel is valid right after reset");
      error_count++;
    end
    @(posedge clk);
    #1;

    test_name = "rom_read";
    foreach (rom_idx[i]) begin
      issue_read(rom_base + rom_idx[i] * 4);
    end
    test_name = "dram_random";
    check_dram_random(8);
    test_name = "rom_write";
    issue_write(rom_base + 5 * 4, 32'hDEAD_BEEF, 4'hF);
    issue_read(rom_base + 5 * 4);
    test_name = "decode_error";
    issue_read(32'h0000_0000);
    issue_read(rom_end);
    issue_write(dram_end, 32'h1234_5678, 4'hF);
    issue_write(32'hFFFF_FFFC, 32'h0BAD_F00D, 4'h3);
    issue_read(32'hFFFF_FFFC);
    wait_for_drain();

    test_name = "read_latency";
    check_read_latency(rom_base + 3 * 4);
    wait_for_drain();
    test_name = "backpressure";
    check_backpressure();
    wait_for_drain();

    $display("Responses checked: %0d, errors: %0d", checked_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* rtl/mem_harness_top.sv */
// AXI4-Lite memory harness: boot ROM, DRAM model, DECERR elsewhere
// Responses return in issue order, 3 cycles after the handshake at best
`timescale 1ns/1ps

module mem_harness_top (
  input  logic                clk_i,
  input  logic                ndmreset_n,
  input  logic                awvalid_i,
  input  harness_pkg::addr_t  awaddr_i,
  output logic                awready_o,
  input  logic                wvalid_i,
  input  harness_pkg::data_t  wdata_i,
  input  harness_pkg::strb_t  wstrb_i,
  output logic                wready_o,
  output logic                bvalid_o,
  output harness_pkg::resp_e  bresp_o,
  input  logic                bready_i,
  input  logic                arvalid_i,
  input  harness_pkg::addr_t  araddr_i,
  output logic                arready_o,
  output logic                rvalid_o,
  output harness_pkg::data_t  rdata_o,
  output harness_pkg::resp_e  rresp_o,
  input  logic                rready_i
);

  logic                    pop;
  logic                    req_valid, req_write;
  harness_pkg::addr_t      req_addr;
  harness_pkg::data_t      req_wdata;
  harness_pkg::strb_t      req_strb;
  logic                    dec_valid, dec_write;
  harness_pkg::region_e    dec_region;
  harness_pkg::word_idx_t  dec_index;
  harness_pkg::data_t      dec_wdata;
  harness_pkg::strb_t      dec_strb;
  logic                    acc_valid, acc_write;
  harness_pkg::resp_e      acc_resp;
  harness_pkg::data_t      acc_rdata;

  axil_req_stage i_req (
    .clk_i, .ndmreset_n,
    .awvalid_i, .awaddr_i, .wvalid_i, .wdata_i, .wstrb_i,
    .awready_o, .wready_o,
    .arvalid_i, .araddr_i, .arready_o,
    .pop_i       ( pop       ),
    .req_valid_o ( req_valid ),
    .req_write_o ( req_write ),
    .req_addr_o  ( req_addr  ),
    .req_wdata_o ( req_wdata ),
    .req_strb_o  ( req_strb  )
  );

  region_decode_stage i_decode (
    .clk_i, .ndmreset_n,
    .req_valid_i  ( req_valid  ),
    .req_write_i  ( req_write  ),
    .req_addr_i   ( req_addr   ),
    .req_wdata_i  ( req_wdata  ),
    .req_strb_i   ( req_strb   ),
    .dec_valid_o  ( dec_valid  ),
    .dec_write_o  ( dec_write  ),
    .dec_region_o ( dec_region ),
    .dec_index_o  ( dec_index  ),
    .dec_wdata_o  ( dec_wdata  ),
    .dec_strb_o   ( dec_strb   )
  );

  mem_access_stage i_access (
    .clk_i, .ndmreset_n,
    .dec_valid_i  ( dec_valid  ),
    .dec_write_i  ( dec_write  ),
    .dec_region_i ( dec_region ),
    .dec_index_i  ( dec_index  ),
    .dec_wdata_i  ( dec_wdata  ),
    .dec_strb_i   ( dec_strb   ),
    .acc_valid_o  ( acc_valid  ),
    .acc_write_o  ( acc_write  ),
    .acc_resp_o   ( acc_resp   ),
    .acc_rdata_o  ( acc_rdata  )
  );

  axil_resp_stage i_resp (
    .clk_i, .ndmreset_n,
    .acc_valid_i ( acc_valid ),
    .acc_write_i ( acc_write ),
    .acc_resp_i  ( acc_resp  ),
    .acc_rdata_i ( acc_rdata ),
    .bvalid_o, .bresp_o, .bready_i,
    .rvalid_o, .rresp_o, .rdata_o, .rready_i,
    .pop_o       ( pop       )
  );

endmodule

/* rtl/axil_resp_stage.sv */
// In-order response queue feeding the B and R channels
// No full check here, the request stage credits keep it from overflowing
`timescale 1ns/1ps
`include "harness_config.svh"

module axil_resp_stage (
  input  logic                clk_i,
  input  logic                ndmreset_n,
  input  logic                acc_valid_i,
  input  logic                acc_write_i,
  input  harness_pkg::resp_e  acc_resp_i,
  input  harness_pkg::data_t  acc_rdata_i,
  output logic                bvalid_o,
  output harness_pkg::resp_e  bresp_o,
  input  logic                bready_i,
  output logic                rvalid_o,
  output harness_pkg::resp_e  rresp_o,
  output harness_pkg::data_t  rdata_o,
  input  logic                rready_i,
  output logic                pop_o
);

  import harness_pkg::*;

  localparam int unsigned depth = `HARNESS_RESP_DEPTH;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;

  logic              write_q [depth];
  resp_e             resp_q  [depth];
  data_t             data_q  [depth];
  logic [ptr_w-1:0]  wr_ptr_q;
  logic [ptr_w-1:0]  rd_ptr_q;
  count_t            count_q;
  logic              not_empty;

  assign not_empty = (count_q != '0);

  // Head entry selects its channel
  assign bvalid_o = not_empty & write_q[rd_ptr_q];
  assign rvalid_o = not_empty & ~write_q[rd_ptr_q];
  assign bresp_o  = resp_q[rd_ptr_q];
  assign rresp_o  = resp_q[rd_ptr_q];
  assign rdata_o  = data_q[rd_ptr_q];
  assign pop_o    = (bvalid_o & bready_i) | (rvalid_o & rready_i);

  always_ff @(posedge clk_i) begin
    if (acc_valid_i) begin
      write_q[wr_ptr_q] <= acc_write_i;
      resp_q[wr_ptr_q]  <= acc_resp_i;
      data_q[wr_ptr_q]  <= acc_rdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (acc_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_o) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({acc_valid_i, pop_o})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* rtl/mem_access_stage.sv */
// ROM and DRAM access, one register stage
// ROM content is computed, TAG in the upper half and word index below
// DRAM powers up undefined and has byte write enables
`timescale 1ns/1ps
`include "harness_config.svh"

module mem_access_stage (
  input  logic                    clk_i,
  input  logic                    ndmreset_n,
  input  logic                    dec_valid_i,
  input  logic                    dec_write_i,
  input  harness_pkg::region_e    dec_region_i,
  input  harness_pkg::word_idx_t  dec_index_i,
  input  harness_pkg::data_t      dec_wdata_i,
  input  harness_pkg::strb_t      dec_strb_i,
  output logic                    acc_valid_o,
  output logic                    acc_write_o,
  output harness_pkg::resp_e      acc_resp_o,
  output harness_pkg::data_t      acc_rdata_o
);

  import harness_pkg::*;

  data_t   dram_q [`HARNESS_DRAM_WORDS];
  logic    dram_we;
  resp_e   resp_d;
  data_t   word_d;
  data_t   rdata_d;

  always_comb begin
    word_d = '0;
    case (dec_region_i)
      REGION_ROM: begin
        // Writes to ROM are refused
        resp_d = dec_write_i ? RESP_SLVERR : RESP_OKAY;
        word_d = data_t'({`HARNESS_ROM_TAG, 16'(dec_index_i)});
      end
      REGION_DRAM: begin
        resp_d = RESP_OKAY;
        word_d = dram_q[dec_index_i];
      end
      default: resp_d = RESP_DECERR;
    endcase
    rdata_d = (!dec_write_i && resp_d == RESP_OKAY) ? word_d : '0;
  end

  assign dram_we = dec_valid_i & dec_write_i & (dec_region_i == REGION_DRAM);

  // ----------------------------------------------------------------------
  // DRAM array
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < `HARNESS_DATA_W / 8; b++) begin
      if (dram_we && dec_strb_i[b]) begin
        dram_q[dec_index_i][b*8 +: 8] <= dec_wdata_i[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      acc_valid_o <= 1'b0;
    end else begin
      acc_valid_o <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    acc_write_o <= dec_write_i;
    acc_resp_o  <= resp_d;
    acc_rdata_o <= rdata_d;
  end

endmodule

/* rtl/region_decode_stage.sv */
// Region decode, one register stage
// Sub-word address bits are dropped, accesses are whole words
`timescale 1ns/1ps
`include "harness_config.svh"

module region_decode_stage (
  input  logic                    clk_i,
  input  logic                    ndmreset_n,
  input  logic                    req_valid_i,
  input  logic                    req_write_i,
  input  harness_pkg::addr_t      req_addr_i,
  input  harness_pkg::data_t      req_wdata_i,
  input  harness_pkg::strb_t      req_strb_i,
  output logic                    dec_valid_o,
  output logic                    dec_write_o,
  output harness_pkg::region_e    dec_region_o,
  output harness_pkg::word_idx_t  dec_index_o,
  output harness_pkg::data_t      dec_wdata_o,
  output harness_pkg::strb_t      dec_strb_o
);

  import harness_pkg::*;

  localparam addr_t rom_lo  = `HARNESS_ROM_BASE;
  localparam addr_t rom_hi  = rom_lo + `HARNESS_ROM_WORDS * 4;
  localparam addr_t dram_lo = `HARNESS_DRAM_BASE;
  localparam addr_t dram_hi = dram_lo + `HARNESS_DRAM_WORDS * 4;

  region_e region_d;
  addr_t   offset_d;

  always_comb begin
    if ((req_addr_i >= rom_lo) && (req_addr_i < rom_hi)) begin
      region_d = REGION_ROM;
      offset_d = req_addr_i - rom_lo;
    end else if ((req_addr_i >= dram_lo) && (req_addr_i < dram_hi)) begin
      region_d = REGION_DRAM;
      offset_d = req_addr_i - dram_lo;
    end else begin
      region_d = REGION_NONE;
      offset_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= req_valid_i;
    end
  end

  // Payload follows valid
  always_ff @(posedge clk_i) begin
    dec_write_o  <= req_write_i;
    dec_region_o <= region_d;
    dec_index_o  <= offset_d[$bits(word_idx_t)+1:2];
    dec_wdata_o  <= req_wdata_i;
    dec_strb_o   <= req_strb_i;
  end

endmodule

/* rtl/axil_req_stage.sv */
// AXI4-Lite request acceptance
// A write needs AW and W valid in the same cycle; writes win over reads
// At most HARNESS_RESP_DEPTH requests are in flight
`timescale 1ns/1ps
`include "harness_config.svh"

module axil_req_stage (
  input  logic                clk_i,
  input  logic                ndmreset_n,
  // Write address and data
  input  logic                awvalid_i,
  input  harness_pkg::addr_t  awaddr_i,
  input  logic                wvalid_i,
  input  harness_pkg::data_t  wdata_i,
  input  harness_pkg::strb_t  wstrb_i,
  output logic                awready_o,
  output logic                wready_o,
  // Read address
  input  logic                arvalid_i,
  input  harness_pkg::addr_t  araddr_i,
  output logic                arready_o,
  // Credit return from the response queue
  input  logic                pop_i,
  // Request stream to the decoder
  output logic                req_valid_o,
  output logic                req_write_o,
  output harness_pkg::addr_t  req_addr_o,
  output harness_pkg::data_t  req_wdata_o,
  output harness_pkg::strb_t  req_strb_o
);

  import harness_pkg::*;

  count_t outstanding_q;
  logic   has_credit;
  logic   wr_offer;
  logic   wr_go;
  logic   rd_go;
  logic   accept;

  assign has_credit = (outstanding_q != count_t'(`HARNESS_RESP_DEPTH));
  assign wr_offer   = awvalid_i & wvalid_i;

  // Write first, read only when no complete write is offered
  assign wr_go  = wr_offer & has_credit;
  assign rd_go  = arvalid_i & ~wr_offer & has_credit;
  assign accept = wr_go | rd_go;

  assign awready_o = wr_go;
  assign wready_o  = wr_go;
  assign arready_o = rd_go;

  assign req_valid_o = accept;
  assign req_write_o = wr_go;
  assign req_addr_o  = wr_go ? awaddr_i : araddr_i;
  assign req_wdata_o = wdata_i;
  assign req_strb_o  = wr_go ? wstrb_i : '0;

  // ----------------------------------------------------------------------
  // Outstanding credits
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      outstanding_q <= '0;
    end else begin
      case ({accept, pop_i})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: outstanding_q <= outstanding_q;
      endcase
    end
  end

endmodule

/* rtl/harness_pkg.sv */
// Shared types of the memory harness
// word_idx_t is sized for the larger of the two regions
`include "harness_config.svh"

package harness_pkg;

  typedef logic [`HARNESS_ADDR_W-1:0]   addr_t;
  typedef logic [`HARNESS_DATA_W-1:0]   data_t;
  typedef logic [`HARNESS_DATA_W/8-1:0] strb_t;

  typedef logic [$clog2((`HARNESS_DRAM_WORDS > `HARNESS_ROM_WORDS) ?
                        `HARNESS_DRAM_WORDS : `HARNESS_ROM_WORDS)-1:0] word_idx_t;

  // Outstanding request and queue occupancy, 0 up to the queue depth
  typedef logic [$clog2(`HARNESS_RESP_DEPTH+1)-1:0] count_t;

  typedef enum logic [1:0] {
    REGION_ROM,
    REGION_DRAM,
    REGION_NONE
  } region_e;

  // AXI response codes, EXOKAY unused
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } resp_e;

endpackage

/* rtl/harness_config.svh */
// Address map and sizing of the memory harness
// ROM and DRAM windows are word aligned and must not overlap
// HARNESS_RESP_DEPTH also bounds the number of outstanding requests
`ifndef HARNESS_CONFIG_SVH
`define HARNESS_CONFIG_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------
`define HARNESS_ADDR_W      32
`define HARNESS_DATA_W      32

// ----------------------------------------------------------------------
// Address map
// ----------------------------------------------------------------------
`define HARNESS_ROM_BASE    32'h0001_0000
`define HARNESS_ROM_WORDS   64
`define HARNESS_DRAM_BASE   32'h8000_0000
`define HARNESS_DRAM_WORDS  256

// Upper half of every ROM word
`define HARNESS_ROM_TAG     16'hB007

`define HARNESS_RESP_DEPTH  4

`endif
